//--- dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// geometry of the direct mapped array
`define DCACHE_LINES       4
`define DCACHE_BLOCK_BYTES 16
`define DCACHE_BEATS       4

// address split: tag | index | offset
`define DCACHE_OFFSET_W    4
`define DCACHE_INDEX_W     2
`define DCACHE_TAG_W       26

// axi encodings used for line transfers
`define DCACHE_BURST_LEN   8'd3
`define DCACHE_WORD_SIZE   3'd2

// cacheable window, everything else goes out uncached
`define DCACHE_CACHED_BASE 32'h8000_0000
`define DCACHE_CACHED_END  32'h9FFF_FFFF

`endif

//--- dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_HIT,
        ST_MISS_WB,
        ST_MISS_LOAD,
        ST_FLUSH_SCAN,
        ST_FLUSH_WB
    } dcache_state_t;

    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;

    // word position inside a line, also the burst beat count
    typedef logic [1:0] beat_t;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef logic [`DCACHE_BLOCK_BYTES*8-1:0] line_t;

endpackage

//--- dcache_store.sv
`include "dcache_macros.svh"

module dcache_store
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t lookup_index,
    input  tag_t   lookup_tag,
    input  logic   hit_write,
    input  word_t  hit_wdata,
    input  strb_t  hit_wstrb,
    input  beat_t  hit_offset,
    input  logic   fill_commit,
    input  logic   clean,
    input  logic   beat_we,
    input  beat_t  beat_idx,
    input  word_t  fill_word,
    output logic   hit,
    output logic   victim_dirty,
    output tag_t   victim_tag,
    output word_t  hit_rdata,
    output word_t  beat_rdata
);

    tag_t  tags [`DCACHE_LINES];
    line_t data [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] valid_q;
    logic [`DCACHE_LINES-1:0] dirty_q;

    assign hit          = valid_q[lookup_index] && (tags[lookup_index] == lookup_tag);
    assign victim_dirty = valid_q[lookup_index] && dirty_q[lookup_index];
    assign victim_tag   = tags[lookup_index];
    assign hit_rdata    = data[lookup_index][32*hit_offset +: 32];
    assign beat_rdata   = data[lookup_index][32*beat_idx +: 32];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (hit_write) begin
                dirty_q[lookup_index] <= 1'b1;
            end
            // a fresh line arrives clean
            if (fill_commit) begin
                valid_q[lookup_index] <= 1'b1;
                dirty_q[lookup_index] <= 1'b0;
            end
            if (clean) begin
                dirty_q[lookup_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            for (int b = 0; b < 4; b++) begin
                if (hit_wstrb[b]) begin
                    data[lookup_index][32*hit_offset + 8*b +: 8] <= hit_wdata[8*b +: 8];
                end
            end
        end
        if (beat_we) begin
            data[lookup_index][32*beat_idx +: 32] <= fill_word;
        end
        if (fill_commit) begin
            tags[lookup_index] <= lookup_tag;
        end
    end

    // a fill never overlaps a hit store
    assert property (@(posedge clk) disable iff (rst) !(hit_write && beat_we));

endmodule

//--- dcache_ctrl.sv
`include "dcache_macros.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        we,
    input  logic [31:0] addr,
    input  word_t       wdata,
    input  strb_t       wstrb,
    input  logic [2:0]  size,
    input  logic        fencei,
    input  logic        hit,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    input  logic        wr_done,
    input  logic        rd_done,
    input  word_t       hit_rdata,
    input  word_t       rd_word,
    output logic        valid,
    output word_t       rdata,
    output logic        flush_done,
    output index_t      lookup_index,
    output tag_t        lookup_tag,
    output logic        hit_write,
    output word_t       hit_wdata,
    output strb_t       hit_wstrb,
    output beat_t       hit_offset,
    output logic        fill_commit,
    output logic        clean,
    output logic        start_wr,
    output logic        start_rd,
    output logic        burst,
    output logic [31:0] wr_addr,
    output logic [31:0] rd_addr,
    output logic [2:0]  size_out,
    output word_t       wr_word,
    output strb_t       wr_strb
);

    dcache_state_t state;
    logic        cached;
    logic        saved_we;
    logic [31:0] saved_addr;
    word_t       saved_wdata;
    strb_t       saved_wstrb;
    logic [2:0]  saved_size;
    index_t      cur_idx;
    logic        in_win;
    logic        last_idx;

    assign in_win   = (addr >= `DCACHE_CACHED_BASE) && (addr <= `DCACHE_CACHED_END);
    assign last_idx = (cur_idx == index_t'(`DCACHE_LINES - 1));

    assign lookup_index = cur_idx;
    assign lookup_tag   = saved_addr[31 -: `DCACHE_TAG_W];
    assign hit_offset   = saved_addr[3:2];
    assign hit_wdata    = saved_wdata;
    assign hit_wstrb    = saved_wstrb;
    assign hit_write    = (state == ST_HIT) && saved_we;
    assign fill_commit  = (state == ST_MISS_LOAD) && rd_done && cached;
    assign clean        = (state == ST_FLUSH_WB) && wr_done;

    // line transfers for cacheable work and the fence walk
    assign burst    = cached;
    assign wr_addr  = cached ? {victim_tag, cur_idx, {`DCACHE_OFFSET_W{1'b0}}} : saved_addr;
    assign rd_addr  = cached ? {saved_addr[31:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}}
                             : saved_addr;
    assign size_out = saved_size;
    assign wr_word  = saved_wdata;
    assign wr_strb  = saved_wstrb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            valid      <= 1'b0;
            flush_done <= 1'b0;
            start_wr   <= 1'b0;
            start_rd   <= 1'b0;
            cached     <= 1'b0;
            cur_idx    <= '0;
        end else begin
            valid      <= 1'b0;
            flush_done <= 1'b0;
            start_wr   <= 1'b0;
            start_rd   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fencei) begin
                        cached  <= 1'b1;
                        cur_idx <= '0;
                        state   <= ST_FLUSH_SCAN;
                    end else if (req) begin
                        cached  <= in_win;
                        cur_idx <= addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
                        if (in_win) begin
                            state <= ST_LOOKUP;
                        end else if (we) begin
                            state    <= ST_MISS_WB;
                            start_wr <= 1'b1;
                        end else begin
                            state    <= ST_MISS_LOAD;
                            start_rd <= 1'b1;
                        end
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        state <= ST_HIT;
                    end else if (victim_dirty) begin
                        state    <= ST_MISS_WB;
                        start_wr <= 1'b1;
                    end else begin
                        state    <= ST_MISS_LOAD;
                        start_rd <= 1'b1;
                    end
                end
                ST_HIT: begin
                    valid <= 1'b1;
                    state <= ST_IDLE;
                end
                ST_MISS_WB: begin
                    if (wr_done && cached) begin
                        state    <= ST_MISS_LOAD;
                        start_rd <= 1'b1;
                    end else if (wr_done) begin
                        valid <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_MISS_LOAD: begin
                    // cacheable fills replay the lookup
                    if (rd_done && cached) begin
                        state <= ST_LOOKUP;
                    end else if (rd_done) begin
                        valid <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_FLUSH_SCAN: begin
                    if (victim_dirty) begin
                        state    <= ST_FLUSH_WB;
                        start_wr <= 1'b1;
                    end else if (last_idx) begin
                        flush_done <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        cur_idx <= cur_idx + 1'b1;
                    end
                end
                ST_FLUSH_WB: begin
                    if (wr_done && last_idx) begin
                        flush_done <= 1'b1;
                        state      <= ST_IDLE;
                    end else if (wr_done) begin
                        cur_idx <= cur_idx + 1'b1;
                        state   <= ST_FLUSH_SCAN;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && req && !fencei) begin
            saved_we    <= we;
            saved_addr  <= addr;
            saved_wdata <= wdata;
            saved_wstrb <= wstrb;
            saved_size  <= size;
        end
        if ((state == ST_HIT) && !saved_we) begin
            rdata <= hit_rdata;
        end else if ((state == ST_MISS_LOAD) && rd_done && !cached) begin
            rdata <= rd_word;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(start_wr && start_rd));
    assert property (@(posedge clk) disable iff (rst) valid |=> !valid);

endmodule

//--- dcache_axi_master.sv
`include "dcache_macros.svh"

module dcache_axi_master
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_wr,
    input  logic        start_rd,
    input  logic        burst,
    input  logic [31:0] wr_addr,
    input  logic [31:0] rd_addr,
    input  logic [2:0]  size,
    input  word_t       wr_word,
    input  strb_t       wr_strb,
    input  word_t       beat_rdata,
    output logic        wr_done,
    output logic        rd_done,
    output logic        beat_we,
    output beat_t       beat_idx,
    output word_t       fill_word,
    output word_t       rd_word,
    output logic        axi_arvalid,
    input  logic        axi_arready,
    output logic [31:0] axi_araddr,
    output logic [7:0]  axi_arlen,
    output logic [2:0]  axi_arsize,
    input  logic        axi_rvalid,
    output logic        axi_rready,
    input  word_t       axi_rdata,
    input  logic        axi_rlast,
    output logic        axi_awvalid,
    input  logic        axi_awready,
    output logic [31:0] axi_awaddr,
    output logic [7:0]  axi_awlen,
    output logic [2:0]  axi_awsize,
    output logic        axi_wvalid,
    input  logic        axi_wready,
    output word_t       axi_wdata,
    output strb_t       axi_wstrb,
    output logic        axi_wlast,
    input  logic        axi_bvalid
);

    logic  wr_busy;
    logic  wr_burst;
    logic  rd_burst;
    logic  aw_ok;
    logic  w_ok;
    logic  b_ok;
    beat_t wbeat;
    beat_t rbeat;

    // one beat index shared by write-out and fill
    assign beat_idx  = wr_busy ? wbeat : rbeat;
    assign beat_we   = axi_rvalid && axi_rready && rd_burst;
    assign fill_word = axi_rdata;
    assign axi_wdata = wr_burst ? beat_rdata : wr_word;
    assign axi_wstrb = wr_burst ? 4'hf : wr_strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            axi_wlast   <= 1'b0;
            wr_busy     <= 1'b0;
            wr_done     <= 1'b0;
            wbeat       <= '0;
        end else begin
            wr_done <= 1'b0;
            if (start_wr) begin
                axi_awvalid <= 1'b1;
                axi_awaddr  <= wr_addr;
                axi_awlen   <= burst ? `DCACHE_BURST_LEN : 8'd0;
                axi_awsize  <= burst ? `DCACHE_WORD_SIZE : size;
                axi_wvalid  <= 1'b1;
                axi_wlast   <= !burst;
                wr_burst    <= burst;
                wr_busy     <= 1'b1;
                wbeat       <= '0;
                aw_ok       <= 1'b0;
                w_ok        <= 1'b0;
                b_ok        <= 1'b0;
            end else if (wr_busy) begin
                if (axi_awvalid && axi_awready) begin
                    axi_awvalid <= 1'b0;
                    aw_ok       <= 1'b1;
                end
                if (axi_wvalid && axi_wready && axi_wlast) begin
                    axi_wvalid <= 1'b0;
                    axi_wlast  <= 1'b0;
                    w_ok       <= 1'b1;
                end else if (axi_wvalid && axi_wready) begin
                    wbeat     <= wbeat + 1'b1;
                    axi_wlast <= (wbeat == 2'd2);
                end
                if (axi_bvalid) begin
                    b_ok <= 1'b1;
                end
                if (aw_ok && w_ok && b_ok) begin
                    wr_busy <= 1'b0;
                    wr_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_arvalid <= 1'b0;
            axi_rready  <= 1'b0;
            rd_done     <= 1'b0;
            rbeat       <= '0;
        end else begin
            rd_done <= 1'b0;
            if (start_rd) begin
                axi_arvalid <= 1'b1;
                axi_araddr  <= rd_addr;
                axi_arlen   <= burst ? `DCACHE_BURST_LEN : 8'd0;
                axi_arsize  <= burst ? `DCACHE_WORD_SIZE : size;
                axi_rready  <= 1'b1;
                rd_burst    <= burst;
                rbeat       <= '0;
            end else begin
                if (axi_arvalid && axi_arready) begin
                    axi_arvalid <= 1'b0;
                end
                if (axi_rvalid && axi_rready) begin
                    rbeat   <= rbeat + 1'b1;
                    rd_word <= axi_rdata;
                    if (axi_rlast) begin
                        axi_rready <= 1'b0;
                        rd_done    <= 1'b1;
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) axi_wlast |-> axi_wvalid);
    // fill beat 3 must be the last one
    assert property (@(posedge clk) disable iff (rst)
        (beat_we && !axi_rlast) |-> (beat_idx != 2'd3));

endmodule

//--- dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        we,
    input  logic [31:0] addr,
    input  word_t       wdata,
    input  strb_t       wstrb,
    input  logic [2:0]  size,
    input  logic        fencei,
    output logic        valid,
    output word_t       rdata,
    output logic        flush_done,
    output logic        axi_arvalid,
    input  logic        axi_arready,
    output logic [31:0] axi_araddr,
    output logic [7:0]  axi_arlen,
    output logic [2:0]  axi_arsize,
    input  logic        axi_rvalid,
    output logic        axi_rready,
    input  word_t       axi_rdata,
    input  logic        axi_rlast,
    output logic        axi_awvalid,
    input  logic        axi_awready,
    output logic [31:0] axi_awaddr,
    output logic [7:0]  axi_awlen,
    output logic [2:0]  axi_awsize,
    output logic        axi_wvalid,
    input  logic        axi_wready,
    output word_t       axi_wdata,
    output strb_t       axi_wstrb,
    output logic        axi_wlast,
    input  logic        axi_bvalid
);

    // controller to store
    index_t lookup_index;
    tag_t   lookup_tag;
    tag_t   victim_tag;
    logic   hit;
    logic   victim_dirty;
    logic   hit_write;
    word_t  hit_wdata;
    strb_t  hit_wstrb;
    beat_t  hit_offset;
    word_t  hit_rdata;
    logic   fill_commit;
    logic   clean;

    // controller to axi master
    logic        start_wr;
    logic        start_rd;
    logic        burst;
    logic        wr_done;
    logic        rd_done;
    logic [31:0] wr_addr;
    logic [31:0] rd_addr;
    logic [2:0]  size_out;
    word_t       wr_word;
    strb_t       wr_strb;
    word_t       rd_word;

    // axi master to store
    logic  beat_we;
    beat_t beat_idx;
    word_t fill_word;
    word_t beat_rdata;

    dcache_ctrl u_ctrl (.*);

    dcache_store u_store (.*);

    dcache_axi_master u_axi_master (
        .*,
        .size(size_out)
    );

endmodule

//--- tb_axi_mem.sv
module tb_axi_mem
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    output logic        rvalid,
    input  logic        rready,
    output word_t       rdata,
    output logic        rlast,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic        wvalid,
    output logic        wready,
    input  word_t       wdata,
    input  strb_t       wstrb,
    input  logic        wlast,
    output logic        bvalid
);

    // one 32 KiB slice per window, picked by address bit 31
    word_t          mem [16384];
    logic [16383:0] written;

    logic [31:0] rnd;
    logic        aw_got;
    logic [31:0] waddr;
    logic [7:0]  wlen;
    logic [7:0]  wcnt;
    logic        ar_got;
    logic [31:0] raddr;
    logic [7:0]  rlen;
    logic [7:0]  rcnt;
    logic [31:0] w_cur;
    logic [31:0] r_cur;

    int burst_writes;
    int single_writes;
    int burst_reads;
    int single_reads;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned word_index(input logic [31:0] a);
        return {18'd0, a[31], a[14:2]};
    endfunction

    // untouched words read as their own address xor 5a5a5a5a
    function automatic word_t read_word(input logic [31:0] a);
        if (written[word_index(a)]) begin
            return mem[word_index(a)];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_5a5a;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t strb);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    assign w_cur   = waddr + {22'd0, wcnt, 2'b00};
    assign r_cur   = raddr + {22'd0, rcnt, 2'b00};
    assign awready = !aw_got && rnd[0];
    assign wready  = aw_got && rnd[3];
    assign arready = !ar_got && rnd[7];
    assign rvalid  = ar_got && rnd[11];
    assign rlast   = (rcnt == rlen);

    always_comb begin
        rdata = read_word(r_cur);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd           <= 32'h9f0f_d9c3;
            written       <= '0;
            aw_got        <= 1'b0;
            ar_got        <= 1'b0;
            bvalid        <= 1'b0;
            wcnt          <= '0;
            rcnt          <= '0;
            burst_writes  <= 0;
            single_writes <= 0;
            burst_reads   <= 0;
            single_reads  <= 0;
        end else begin
            rnd    <= xorshift(rnd);
            bvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                waddr  <= awaddr;
                wlen   <= awlen;
                wcnt   <= '0;
            end
            if (wvalid && wready) begin
                mem[word_index(w_cur)]     <= merge_bytes(read_word(w_cur), wdata, wstrb);
                written[word_index(w_cur)] <= 1'b1;
                wcnt <= wcnt + 8'd1;
                if (wlast) begin
                    aw_got <= 1'b0;
                    bvalid <= 1'b1;
                    if (wlen == 8'd0) begin
                        single_writes <= single_writes + 1;
                    end else begin
                        burst_writes <= burst_writes + 1;
                    end
                end
            end
            if (arvalid && arready) begin
                ar_got <= 1'b1;
                raddr  <= araddr;
                rlen   <= arlen;
                rcnt   <= '0;
            end
            if (rvalid && rready) begin
                rcnt <= rcnt + 8'd1;
                if (rlast) begin
                    ar_got <= 1'b0;
                    if (rlen == 8'd0) begin
                        single_reads <= single_reads + 1;
                    end else begin
                        burst_reads <= burst_reads + 1;
                    end
                end
            end
        end
    end

endmodule

//--- tb_dcache.sv
`include "dcache_macros.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 2000;
    localparam int MAX_VEC = 64;
    localparam int FIELDS  = 6;

    localparam logic [31:0] OP_LOAD  = 32'd0;
    localparam logic [31:0] OP_STORE = 32'd1;
    localparam logic [31:0] OP_FENCE = 32'd2;
    localparam logic [31:0] OP_CHECK = 32'd3;

    logic        clk;
    logic        rst;
    logic        req;
    logic        we;
    logic [31:0] addr;
    word_t       wdata;
    strb_t       wstrb;
    logic [2:0]  size;
    logic        fencei;
    logic        valid;
    word_t       rdata;
    logic        flush_done;

    logic        axi_arvalid;
    logic        axi_arready;
    logic [31:0] axi_araddr;
    logic [7:0]  axi_arlen;
    logic [2:0]  axi_arsize;
    logic        axi_rvalid;
    logic        axi_rready;
    word_t       axi_rdata;
    logic        axi_rlast;
    logic        axi_awvalid;
    logic        axi_awready;
    logic [31:0] axi_awaddr;
    logic [7:0]  axi_awlen;
    logic [2:0]  axi_awsize;
    logic        axi_wvalid;
    logic        axi_wready;
    word_t       axi_wdata;
    strb_t       axi_wstrb;
    logic        axi_wlast;
    logic        axi_bvalid;

    logic [31:0] vec [MAX_VEC*FIELDS];
    int          errors;
    bit          hung;
    logic [2:0]  aw_size_seen;
    logic [2:0]  ar_size_seen;

    dcache_top u_dcache_top (.*);

    tb_axi_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .arvalid (axi_arvalid),
        .arready (axi_arready),
        .araddr  (axi_araddr),
        .arlen   (axi_arlen),
        .rvalid  (axi_rvalid),
        .rready  (axi_rready),
        .rdata   (axi_rdata),
        .rlast   (axi_rlast),
        .awvalid (axi_awvalid),
        .awready (axi_awready),
        .awaddr  (axi_awaddr),
        .awlen   (axi_awlen),
        .wvalid  (axi_wvalid),
        .wready  (axi_wready),
        .wdata   (axi_wdata),
        .wstrb   (axi_wstrb),
        .wlast   (axi_wlast),
        .bvalid  (axi_bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // size of the last accepted address on each channel
    always @(posedge clk) begin
        if (axi_awvalid && axi_awready) begin
            aw_size_seen <= axi_awsize;
        end
        if (axi_arvalid && axi_arready) begin
            ar_size_seen <= axi_arsize;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_hit_latency(input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: hit took %0d cycles, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s changed by %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_size(input logic [2:0] got, input logic [2:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // word as the model memory holds it
    function automatic word_t mem_word(input logic [31:0] a);
        logic [13:0] idx;
        idx = {a[31], a[14:2]};
        if (u_mem.written[idx]) begin
            return u_mem.mem[idx];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [2:0] size_for(input strb_t s);
        case ($countones(s))
            1:       return 3'd0;
            2:       return 3'd1;
            default: return 3'd2;
        endcase
    endfunction

    function automatic string op_name(input logic [31:0] op);
        case (op)
            OP_LOAD:  return "load";
            OP_STORE: return "store";
            OP_FENCE: return "fence";
            default:  return "check";
        endcase
    endfunction

    // counts cycles from the edge that takes the request
    task automatic wait_pulse(input bit for_flush, output int cycles);
        cycles = 1;
        while (!(for_flush ? flush_done : valid) && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!(for_flush ? flush_done : valid)) begin
            $display("timeout: no %s pulse within %0d cycles",
                     for_flush ? "flush_done" : "valid", TIMEOUT);
            hung = 1'b1;
        end
    endtask

    task automatic run_access(input bit is_store, input logic [31:0] a, input word_t d,
                              input strb_t s, output int cycles);
        req   = 1'b1;
        we    = is_store;
        addr  = a;
        wdata = d;
        wstrb = s;
        size  = is_store ? size_for(s) : 3'd2;
        @(posedge clk);
        #2;
        req = 1'b0;
        wait_pulse(1'b0, cycles);
    endtask

    initial begin
        int          n;
        int          failed;
        int          cycles;
        int          err_mark;
        int          bw;
        int          br;
        int          sw;
        int          sr;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        strb_t       s;
        bit          expect_hit;
        bit          cached;

        rst    = 1'b1;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        wstrb  = '0;
        size   = '0;
        fencei = 1'b0;
        errors = 0;
        hung   = 1'b0;
        n      = 0;
        failed = 0;
        for (int k = 0; k < MAX_VEC*FIELDS; k++) begin
            vec[k] = '1;
        end
        $readmemh("dcache_vectors.txt", vec);

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < MAX_VEC; i++) begin
            op = vec[FIELDS*i];
            if (op > OP_CHECK || hung) begin
                break;
            end
            a          = vec[FIELDS*i+1];
            d          = vec[FIELDS*i+2];
            s          = strb_t'(vec[FIELDS*i+3]);
            e          = vec[FIELDS*i+4];
            expect_hit = vec[FIELDS*i+5][0];
            cached     = (a >= `DCACHE_CACHED_BASE) && (a <= `DCACHE_CACHED_END);
            err_mark   = errors;
            bw         = u_mem.burst_writes;
            br         = u_mem.burst_reads;
            sw         = u_mem.single_writes;
            sr         = u_mem.single_reads;
            case (op)
                OP_LOAD, OP_STORE: begin
                    run_access(op == OP_STORE, a, d, s, cycles);
                    if (!hung) begin
                        if (op == OP_LOAD) begin
                            check_word(rdata, e, "load data");
                        end
                        // hits stay off the bus
                        if (expect_hit) begin
                            check_hit_latency(cycles, 3);
                            check_count("burst writes", u_mem.burst_writes - bw, 0);
                            check_count("burst reads", u_mem.burst_reads - br, 0);
                        end
                        if (!cached && op == OP_LOAD) begin
                            check_count("single reads", u_mem.single_reads - sr, 1);
                            check_size(ar_size_seen, size, "arsize");
                        end
                        if (!cached && op == OP_STORE) begin
                            check_count("single writes", u_mem.single_writes - sw, 1);
                            check_size(aw_size_seen, size, "awsize");
                        end
                        // line bursts move whole words
                        if (cached && u_mem.burst_reads != br) begin
                            check_size(ar_size_seen, 3'd2, "burst arsize");
                        end
                        if (cached && u_mem.burst_writes != bw) begin
                            check_size(aw_size_seen, 3'd2, "burst awsize");
                        end
                    end
                end
                OP_FENCE: begin
                    fencei = 1'b1;
                    @(posedge clk);
                    #2;
                    fencei = 1'b0;
                    wait_pulse(1'b1, cycles);
                end
                default: begin
                    check_word(mem_word(a), e, "memory word");
                end
            endcase
            n++;
            if (errors != err_mark || hung) begin
                failed++;
            end
            $display("test %0d %s %h: %s", n, op_name(op), a,
                     (errors == err_mark && !hung) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, check errors %0d", n, failed, errors);
        if (hung || errors != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

//--- dcache_vectors.txt
// op addr data strb expect hit
// op: 0 load, 1 store, 2 fence, 3 check memory; hit 1 means 3-cycle hit, no bursts
0 80000004 00000000 0 da5a5a5e 0
0 8000000c 00000000 0 da5a5a56 1
1 80000008 11223344 3 00000000 1
0 80000008 00000000 0 da5a3344 1
0 80000100 00000000 0 da5a5b5a 0
3 80000008 00000000 0 da5a3344 0
3 80000004 00000000 0 da5a5a5e 0
0 00001000 00000000 0 5a5a4a5a 0
1 00001002 aabbccdd c 00000000 0
3 00001000 00000000 0 aabb4a5a 0
0 00001000 00000000 0 aabb4a5a 0
1 00001004 000000ee 1 00000000 0
3 00001004 00000000 0 5a5a4aee 0
1 80000010 01020304 f 00000000 0
1 80000024 05060708 f 00000000 0
1 80000104 0a0b0c0d f 00000000 1
1 8000003c ffee0000 c 00000000 0
2 00000000 00000000 0 00000000 0
3 80000010 00000000 0 01020304 0
3 80000024 00000000 0 05060708 0
3 80000104 00000000 0 0a0b0c0d 0
3 8000003c 00000000 0 ffee5a66 0
0 80000024 00000000 0 05060708 1
0 8000003c 00000000 0 ffee5a66 1
3 80000008 00000000 0 da5a3344 0

//--- dcache.f
+incdir+.
dcache_pkg.sv
dcache_store.sv
dcache_ctrl.sv
dcache_axi_master.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f dcache.f

out=$(./obj_dir/Vtb_dcache)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1
